// ==== logic/clic_pkg.sv ====
// pc_width must not exceed xlen, and the entry word carries a 3-bit priority, so at most 8 levels
package clic_pkg;

  // csr data width, shared with the core
  localparam int xlen = 32;

  // each csr bank reserves a window of 32 consecutive addresses
  localparam int max_lines  = 32;
  localparam int line_idx_w = $clog2(max_lines);

  typedef logic [11:0] csr_addr_t;

  typedef enum logic [1:0] {
    csr_none,
    csr_write,
    csr_set,
    csr_clear
  } csr_op_t;

  // fixed controller csrs
  localparam csr_addr_t thresh_addr = 12'h347;
  localparam csr_addr_t depth_addr  = 12'h350;

  // first csr of each per-line bank, aligned to the bank window
  localparam csr_addr_t vec_base   = 12'hb00;
  localparam csr_addr_t entry_base = 12'hb20;

  // one csr data word, read either as a vector or as an entry
  typedef union packed {
    struct packed {
      logic [xlen-3:0] addr;
      logic [1:0]      align;
    } vec;
    struct packed {
      logic [xlen-6:0] pad;
      logic [2:0]      prio;
      logic            enabled;
      logic            pended;
    } entry;
  } csr_word_u;

  // csrrw / csrrs / csrrc on a full word
  function automatic logic [xlen-1:0] csr_apply(csr_op_t op, logic [xlen-1:0] old_val,
                                                logic [xlen-1:0] operand);
    logic [xlen-1:0] res;
    case (op)
      csr_write: res = operand;
      csr_set:   res = old_val | operand;
      csr_clear: res = old_val & ~operand;
      default:   res = old_val;
    endcase
    return res;
  endfunction

endpackage

// ==== logic/clic_vector_table.sv ====
// line_count up to max_lines; pending is set by software only and never cleared by hardware
module clic_vector_table #(
  parameter  int line_count  = 8,
  parameter  int prio_levels = 8,
  parameter  int pc_width    = 32,
  localparam int prio_w      = $clog2(prio_levels)
) (
  input  logic                         clk,
  input  logic                         rst_n,
  input  logic                         csr_enable,
  input  clic_pkg::csr_addr_t          csr_addr,
  input  clic_pkg::csr_op_t            csr_op,
  input  logic [clic_pkg::xlen-1:0]    rs1_data,
  input  logic [prio_w-1:0]            thresh,
  output logic                         int_found,
  output logic [prio_w-1:0]            int_prio,
  output logic [pc_width-1:0]          int_vec,
  output logic [clic_pkg::xlen-1:0]    table_rdata
);

  // per-line state, vectors kept as word addresses
  logic [pc_width-3:0] vec_q   [line_count];
  logic [prio_w-1:0]   prio_q  [line_count];
  logic                en_q    [line_count];
  logic                pend_q  [line_count];

  logic [clic_pkg::line_idx_w-1:0] line;
  logic                            line_ok;
  logic                            vec_hit;
  logic                            entry_hit;
  clic_pkg::csr_word_u             old_u;
  clic_pkg::csr_word_u             new_u;

  logic                best_found;
  logic [prio_w-1:0]   best_prio;
  logic [pc_width-3:0] best_vec;

  // low address bits pick the line inside a bank
  assign line    = csr_addr[clic_pkg::line_idx_w-1:0];
  assign line_ok = int'(line) < line_count;

  // banks are aligned, so the upper bits select the bank
  assign vec_hit = csr_enable && line_ok &&
                   (csr_addr[11:clic_pkg::line_idx_w] ==
                    clic_pkg::vec_base[11:clic_pkg::line_idx_w]);
  assign entry_hit = csr_enable && line_ok &&
                     (csr_addr[11:clic_pkg::line_idx_w] ==
                      clic_pkg::entry_base[11:clic_pkg::line_idx_w]);

  // old value of the addressed csr, formatted as seen by software
  always_comb begin
    old_u = '0;
    for (int k = 0; k < line_count; k++) begin
      if (int'(line) == k) begin
        if (vec_hit) begin
          old_u.vec.addr = (clic_pkg::xlen-2)'(vec_q[k]);
        end else if (entry_hit) begin
          old_u.entry.prio    = 3'(prio_q[k]);
          old_u.entry.enabled = en_q[k];
          old_u.entry.pended  = pend_q[k];
        end
      end
    end
  end

  assign table_rdata = old_u;

  // merged operand, then decoded by whichever bank is addressed
  assign new_u = clic_pkg::csr_apply(csr_op, old_u, rs1_data);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int k = 0; k < line_count; k++) begin
        vec_q[k]  <= '0;
        prio_q[k] <= '0;
        en_q[k]   <= 1'b0;
        pend_q[k] <= 1'b0;
      end
    end else begin
      for (int k = 0; k < line_count; k++) begin
        if (vec_hit && int'(line) == k) begin
          vec_q[k] <= new_u.vec.addr[pc_width-3:0];
        end
        if (entry_hit && int'(line) == k) begin
          prio_q[k] <= new_u.entry.prio[prio_w-1:0];
          en_q[k]   <= new_u.entry.enabled;
          pend_q[k] <= new_u.entry.pended;
        end
      end
    end
  end

  // chained scan from the top line down
  // strict compare, so a tie keeps the higher index
  always_comb begin
    best_found = 1'b0;
    best_prio  = thresh;
    best_vec   = '0;
    for (int k = line_count - 1; k >= 0; k--) begin
      if (en_q[k] && pend_q[k] && (prio_q[k] > best_prio)) begin
        best_found = 1'b1;
        best_prio  = prio_q[k];
        best_vec   = vec_q[k];
      end
    end
  end

  assign int_found = best_found;
  assign int_prio  = best_prio;
  // back to a byte address for the fetch unit
  assign int_vec   = {best_vec, 2'b00};

  // lines must fit the csr window, priorities the 3-bit entry field
  params_fit: assert property (@(posedge clk) disable iff (!rst_n)
    (line_count <= clic_pkg::max_lines) && (prio_levels <= 8))
    else $error("vector table parameters exceed the csr layout");

endmodule

// ==== logic/clic_epc_stack.sv ====
// prio_levels must be a power of two of at least 2; the caller must not push when full
module clic_epc_stack #(
  parameter  int prio_levels = 8,
  parameter  int pc_width    = 32,
  localparam int prio_w      = $clog2(prio_levels),
  localparam int depth_w     = $clog2(prio_levels + 1)
) (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                push,
  input  logic                pop,
  input  logic [pc_width-1:0] push_pc,
  input  logic [prio_w-1:0]   push_prio,
  output logic [pc_width-1:0] top_pc,
  output logic [prio_w-1:0]   top_prio,
  output logic [depth_w-1:0]  depth
);

  // storage index width, one slot per priority level
  localparam int ptr_w = $clog2(prio_levels);

  logic [pc_width-1:0] pc_mem   [prio_levels];
  logic [prio_w-1:0]   prio_mem [prio_levels];
  logic [depth_w-1:0]  depth_q;
  logic [ptr_w-1:0]    wr_ptr;
  logic [ptr_w-1:0]    top_ptr;

  // next free slot and current top
  assign wr_ptr  = ptr_w'(depth_q);
  assign top_ptr = ptr_w'(depth_q - 1'b1);

  // payload only, depth tells what is valid
  always_ff @(posedge clk) begin
    if (push) begin
      pc_mem[wr_ptr]   <= push_pc;
      prio_mem[wr_ptr] <= push_prio;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      depth_q <= '0;
    end else if (push) begin
      depth_q <= depth_q + 1'b1;
    end else if (pop) begin
      depth_q <= depth_q - 1'b1;
    end
  end

  // top visible in the same cycle for a return
  assign top_pc   = pc_mem[top_ptr];
  assign top_prio = prio_mem[top_ptr];
  assign depth    = depth_q;

  no_push_pop: assert property (@(posedge clk) disable iff (!rst_n) !(push && pop))
    else $error("epc stack push and pop in the same cycle");

  // nesting beyond prio_levels would overwrite the oldest frame
  no_overflow: assert property (@(posedge clk) disable iff (!rst_n)
    push |-> (int'(depth_q) < prio_levels))
    else $error("epc stack overflow");

  no_underflow: assert property (@(posedge clk) disable iff (!rst_n)
    pop |-> (depth_q != '0))
    else $error("epc stack underflow");

endmodule

// ==== logic/clic_sequencer.sv ====
// pc all ones marks a return; a hardware threshold update wins over a software write
module clic_sequencer #(
  parameter  int prio_levels = 8,
  parameter  int pc_width    = 32,
  localparam int prio_w      = $clog2(prio_levels),
  localparam int depth_w     = $clog2(prio_levels + 1)
) (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      csr_enable,
  input  clic_pkg::csr_addr_t       csr_addr,
  input  clic_pkg::csr_op_t         csr_op,
  input  logic [clic_pkg::xlen-1:0] rs1_data,
  input  logic [pc_width-1:0]       pc_in,
  input  logic                      int_found,
  input  logic [prio_w-1:0]         int_prio,
  input  logic [pc_width-1:0]       int_vec,
  input  logic [clic_pkg::xlen-1:0] table_rdata,
  input  logic [pc_width-1:0]       top_pc,
  input  logic [prio_w-1:0]         top_prio,
  input  logic [depth_w-1:0]        depth,
  output logic [prio_w-1:0]         thresh,
  output logic                      push,
  output logic                      pop,
  output logic [pc_width-1:0]       push_pc,
  output logic [prio_w-1:0]         push_prio,
  output logic [pc_width-1:0]       pc_out,
  output logic [clic_pkg::xlen-1:0] csr_rdata
);

  logic                      thresh_q;
  logic [prio_w-1:0]         thresh_r;
  logic                      is_ret;
  logic                      hw_we;
  logic [prio_w-1:0]         hw_thresh;
  logic                      thresh_hit;
  logic                      depth_hit;
  logic                      sw_we;
  logic [clic_pkg::xlen-1:0] thresh_new;

  // return from interrupt marker
  assign is_ret = (pc_in == '1);

  // first matching case wins: tail chain, take, return, pass
  always_comb begin
    push      = 1'b0;
    pop       = 1'b0;
    pc_out    = pc_in;
    hw_we     = 1'b0;
    hw_thresh = thresh_r;
    if (is_ret && int_found) begin
      // tail chain, stack and threshold untouched
      pc_out = int_vec;
    end else if (int_found) begin
      push      = 1'b1;
      pc_out    = int_vec;
      hw_we     = 1'b1;
      hw_thresh = int_prio;
    end else if (is_ret) begin
      pop       = 1'b1;
      pc_out    = top_pc;
      hw_we     = 1'b1;
      hw_thresh = top_prio;
    end
  end

  // frame saved on a take
  assign push_pc   = pc_in;
  assign push_prio = thresh_r;

  assign thresh_hit = csr_enable && (csr_addr == clic_pkg::thresh_addr);
  assign depth_hit  = csr_enable && (csr_addr == clic_pkg::depth_addr);

  assign thresh_new = clic_pkg::csr_apply(csr_op, clic_pkg::xlen'(thresh_r), rs1_data);
  assign sw_we      = thresh_hit && (csr_op != clic_pkg::csr_none);

  // threshold register, hardware first
  assign thresh_q = hw_we || sw_we;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      thresh_r <= '0;
    end else if (thresh_q) begin
      if (hw_we) begin
        thresh_r <= hw_thresh;
      end else begin
        thresh_r <= thresh_new[prio_w-1:0];
      end
    end
  end

  assign thresh = thresh_r;

  // read mux, depth is read-only
  // table_rdata is already zero outside its banks
  always_comb begin
    if (thresh_hit) begin
      csr_rdata = clic_pkg::xlen'(thresh_r);
    end else if (depth_hit) begin
      csr_rdata = clic_pkg::xlen'(depth);
    end else begin
      csr_rdata = table_rdata;
    end
  end

  // a plain return needs a saved frame on the stack
  ret_has_frame: assert property (@(posedge clk) disable iff (!rst_n)
    (is_ret && !int_found) |-> (depth != '0))
    else $error("return from interrupt with an empty epc stack");

endmodule

// ==== logic/clic_top.sv ====
// line_count up to 32, prio_levels a power of two from 2 to 8, pc_width at most 32
module clic_top #(
  parameter int line_count  = 8,
  parameter int prio_levels = 8,
  parameter int pc_width    = 32
) (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      csr_enable,
  input  clic_pkg::csr_addr_t       csr_addr,
  input  clic_pkg::csr_op_t         csr_op,
  input  logic [clic_pkg::xlen-1:0] rs1_data,
  input  logic [pc_width-1:0]       pc_in,
  output logic [pc_width-1:0]       pc_out,
  output logic [clic_pkg::xlen-1:0] csr_rdata
);

  localparam int prio_w  = $clog2(prio_levels);
  localparam int depth_w = $clog2(prio_levels + 1);

  // table to sequencer
  logic                      int_found;
  logic [prio_w-1:0]         int_prio;
  logic [pc_width-1:0]       int_vec;
  logic [clic_pkg::xlen-1:0] table_rdata;
  logic [prio_w-1:0]         thresh;

  // stack and sequencer
  logic                push;
  logic                pop;
  logic [pc_width-1:0] push_pc;
  logic [prio_w-1:0]   push_prio;
  logic [pc_width-1:0] top_pc;
  logic [prio_w-1:0]   top_prio;
  logic [depth_w-1:0]  depth;

  clic_vector_table #(
    .line_count (line_count),
    .prio_levels(prio_levels),
    .pc_width   (pc_width)
  ) u_table (
    .clk,
    .rst_n,
    .csr_enable,
    .csr_addr,
    .csr_op,
    .rs1_data,
    .thresh,
    .int_found,
    .int_prio,
    .int_vec,
    .table_rdata
  );

  clic_epc_stack #(
    .prio_levels(prio_levels),
    .pc_width   (pc_width)
  ) u_stack (
    .clk,
    .rst_n,
    .push,
    .pop,
    .push_pc,
    .push_prio,
    .top_pc,
    .top_prio,
    .depth
  );

  clic_sequencer #(
    .prio_levels(prio_levels),
    .pc_width   (pc_width)
  ) u_seq (
    .clk,
    .rst_n,
    .csr_enable,
    .csr_addr,
    .csr_op,
    .rs1_data,
    .pc_in,
    .int_found,
    .int_prio,
    .int_vec,
    .table_rdata,
    .top_pc,
    .top_prio,
    .depth,
    .thresh,
    .push,
    .pop,
    .push_pc,
    .push_prio,
    .pc_out,
    .csr_rdata
  );

endmodule

// ==== sim/clic_tb.sv ====
// runs from the project root, reads sim/clic_trace.txt, drives the dut with default parameters
module clic_tb;

  timeunit 1ns;
  timeprecision 1ps;

  localparam int    reset_cycles = 4;
  localparam string trace_path   = "sim/clic_trace.txt";

  // one clock of stimulus plus the expected outputs
  typedef struct packed {
    logic        en;
    logic [1:0]  op;
    logic [11:0] addr;
    logic [31:0] data;
    logic [31:0] pc_in;
    logic [31:0] pc_out;
    logic [31:0] rdata;
  } trace_row_t;

  logic                      clk;
  logic                      rst_n;
  logic                      csr_enable;
  clic_pkg::csr_addr_t       csr_addr;
  clic_pkg::csr_op_t         csr_op;
  logic [clic_pkg::xlen-1:0] rs1_data;
  logic [31:0]               pc_in;
  logic [31:0]               pc_out;
  logic [clic_pkg::xlen-1:0] csr_rdata;

  trace_row_t rows[$];
  string      names[$];

  int mismatch_count = 0;
  int fault_count    = 0;
  int check_count    = 0;
  int cycle_count    = 0;
  int cycle_limit    = 0;

  clic_top UUT (
    .clk       (clk),
    .rst_n     (rst_n),
    .csr_enable(csr_enable),
    .csr_addr  (csr_addr),
    .csr_op    (csr_op),
    .rs1_data  (rs1_data),
    .pc_in     (pc_in),
    .pc_out    (pc_out),
    .csr_rdata (csr_rdata)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // comment lines and blank lines carry no row
  function automatic bit skip_line(string text);
    logic [7:0] c;
    if (text.len() == 0) begin
      return 1'b1;
    end
    c = text.getc(0);
    return (c == "#") || (c == "\n") || (c == "\r") || (c == " ");
  endfunction

  // whole trace up front, so the run length is known before reset
  task automatic load_trace();
    int          fd;
    int          n;
    int          line_no;
    string       text;
    string       name;
    logic [31:0] en_v;
    logic [31:0] op_v;
    logic [31:0] addr_v;
    logic [31:0] data_v;
    logic [31:0] pcin_v;
    logic [31:0] pcout_v;
    logic [31:0] rdata_v;
    trace_row_t  row;
    fd = $fopen(trace_path, "r");
    if (fd == 0) begin
      fault_count++;
      $display("cannot open the trace file %0s", trace_path);
      return;
    end
    line_no = 0;
    while ($fgets(text, fd) > 0) begin
      line_no++;
      if (skip_line(text)) begin
        continue;
      end
      n = $sscanf(text, "%s %h %h %h %h %h %h %h", name, en_v, op_v, addr_v, data_v,
                  pcin_v, pcout_v, rdata_v);
      // enable is one bit, op two bits, address twelve bits
      if (n != 8 || en_v > 32'd1 || op_v > 32'd3 || addr_v > 32'hfff) begin
        fault_count++;
        $display("trace line %0d is malformed and was skipped", line_no);
      end else begin
        row.en     = en_v[0];
        row.op     = op_v[1:0];
        row.addr   = addr_v[11:0];
        row.data   = data_v;
        row.pc_in  = pcin_v;
        row.pc_out = pcout_v;
        row.rdata  = rdata_v;
        rows.push_back(row);
        names.push_back(name);
      end
    end
    $fclose(fd);
  endtask

  task automatic drive_row(trace_row_t row);
    csr_enable = row.en;
    csr_op     = clic_pkg::csr_op_t'(row.op);
    csr_addr   = row.addr;
    rs1_data   = row.data;
    pc_in      = row.pc_in;
  endtask

  // both outputs are combinational, settled well before the next edge
  task automatic check_row(string name, trace_row_t row);
    check_count++;
    assert (pc_out === row.pc_out) else begin
      mismatch_count++;
      $display("mismatch %0s pc_out expected %08h actual %08h", name, row.pc_out, pc_out);
    end
    assert (csr_rdata === row.rdata) else begin
      mismatch_count++;
      $display("mismatch %0s csr_rdata expected %08h actual %08h", name, row.rdata, csr_rdata);
    end
  endtask

  // watchdog, limit set once the trace is loaded
  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
      $display("timeout after %0d cycles, the trace did not finish", cycle_limit);
      $display("checks %0d, mismatches %0d, other errors %0d", check_count, mismatch_count,
               fault_count);
      $display("Result: FAILED");
      $finish;
    end
  end

  initial begin
    rst_n      = 1'b0;
    csr_enable = 1'b0;
    csr_op     = clic_pkg::csr_none;
    csr_addr   = '0;
    rs1_data   = '0;
    pc_in      = '0;
    load_trace();
    if (rows.size() == 0 && fault_count == 0) begin
      fault_count++;
      $display("the trace file holds no test rows");
    end
    cycle_limit = 2 * rows.size() + reset_cycles;
    repeat (reset_cycles) @(negedge clk);
    rst_n = 1'b1;
    // one row per falling edge
    for (int i = 0; i < rows.size(); i++) begin
      drive_row(rows[i]);
      #10;
      check_row(names[i], rows[i]);
      @(negedge clk);
    end
    $display("checks %0d, mismatches %0d, other errors %0d", check_count, mismatch_count,
             fault_count);
    if (mismatch_count == 0 && fault_count == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

// ==== sim/clic_trace.txt ====
# columns: name csr_enable csr_op csr_addr rs1_data pc_in exp_pc_out exp_csr_rdata
# all numbers hex; csr_op 0 none, 1 write, 2 set, 3 clear; pc ffffffff is the return marker
# reset_pass: pass-through and every csr reads zero
reset_pass 0 0 000 00000000 00000100 00000100 00000000
reset_pass 1 0 b00 00000000 00000104 00000104 00000000
reset_pass 1 0 b27 00000000 00000108 00000108 00000000
reset_pass 1 0 347 00000000 0000010c 0000010c 00000000
reset_pass 1 0 350 00000000 00000110 00000110 00000000
reset_pass 1 0 b08 00000000 00000114 00000114 00000000
# csr_access: threshold write, set, clear, then vector and entry of line 1
csr_access 1 1 347 00000005 00000200 00000200 00000000
csr_access 1 0 347 00000000 00000204 00000204 00000005
csr_access 1 2 347 00000002 00000208 00000208 00000005
csr_access 1 3 347 00000004 0000020c 0000020c 00000007
csr_access 1 0 347 00000000 00000210 00000210 00000003
csr_access 1 1 b01 00002000 00000214 00000214 00000000
csr_access 1 2 b01 00000013 00000218 00000218 00002000
csr_access 1 3 b01 00002000 0000021c 0000021c 00002010
csr_access 1 0 b01 00000000 00000220 00000220 00000010
csr_access 1 1 b21 0000000b 00000224 00000224 00000000
csr_access 1 3 b21 00000002 00000228 00000228 0000000b
csr_access 1 0 b21 00000000 0000022c 0000022c 00000009
# arbitration: lines 2..6 set up under threshold 7, then threshold drops to 3
arbitration 1 1 347 00000007 00000300 00000300 00000003
arbitration 1 1 b02 00003000 00000304 00000304 00000000
arbitration 1 1 b04 00005000 00000308 00000308 00000000
arbitration 1 1 b05 00006000 0000030c 0000030c 00000000
arbitration 1 1 b06 00007000 00000310 00000310 00000000
arbitration 1 1 b22 00000013 00000314 00000314 00000000
arbitration 1 1 b23 0000000f 00000318 00000318 00000000
arbitration 1 1 b24 0000001b 0000031c 0000031c 00000000
arbitration 1 1 b25 0000001b 00000320 00000320 00000000
arbitration 1 1 b26 0000001d 00000324 00000324 00000000
arbitration 1 1 347 00000003 00000328 00000328 00000007
arbitration 1 0 350 00000000 00000400 00006000 00000000
# take_nest: line 5 handler, then line 6 enabled and preempts it
take_nest 1 0 350 00000000 00006000 00006000 00000001
take_nest 1 0 347 00000000 00006004 00006004 00000006
take_nest 1 3 b25 00000001 00006008 00006008 0000001b
take_nest 1 2 b26 00000002 0000600c 0000600c 0000001d
take_nest 1 0 350 00000000 00006010 00007000 00000001
take_nest 1 0 350 00000000 00007000 00007000 00000002
take_nest 1 0 347 00000000 00007004 00007004 00000007
# return_pop: line 6 cleared, return restores pc and threshold of line 5
return_pop 1 3 b26 00000001 00007008 00007008 0000001f
return_pop 1 0 350 00000000 ffffffff 00006010 00000002
return_pop 1 0 350 00000000 00006010 00006010 00000001
return_pop 1 0 347 00000000 00006014 00006014 00000006
# tail_chain: line 6 pending again at the return, stack and threshold kept
tail_chain 1 2 b26 00000001 00006018 00006018 0000001e
tail_chain 1 3 b26 00000001 ffffffff 00007000 0000001f
tail_chain 1 0 350 00000000 00007000 00007000 00000001
tail_chain 1 0 347 00000000 00007004 00007004 00000006
# final_return: stack empties, then line 4 is taken under threshold 3
final_return 1 0 350 00000000 ffffffff 00000400 00000001
final_return 1 0 350 00000000 00000400 00005000 00000000
final_return 1 0 350 00000000 00005000 00005000 00000001

// ==== sim.f ====
logic/clic_pkg.sv
logic/clic_vector_table.sv
logic/clic_epc_stack.sv
logic/clic_sequencer.sv
logic/clic_top.sv
sim/clic_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# builds the testbench with verilator from sim.f, runs it into sim.log and scans the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --timescale 1ns/1ps -f sim.f \
  --top-module clic_tb -o clic_sim \
  && ./obj_dir/clic_sim > sim.log 2>&1 \
  || { cat sim.log 2>/dev/null; echo "build or simulation run failed"; exit 1; }
cat sim.log
grep -q "Result: FAILED" sim.log && { echo "simulation reported failure"; exit 1; }
grep -q "Result: PASSED" sim.log || { echo "no pass line found in sim.log"; exit 1; }
exit 0
